//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_wr_tlp_gen
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
+incdir+verilog
verilog/pcie_tlp_pkg.sv
verilog/afu_wr_pkg.sv
verilog/fence_tag_if.sv
verilog/fifo2.sv
verilog/fence_tag_pool.sv
verilog/wr_req_sequencer.sv
verilog/tlp_builder.sv
verilog/wr_rsp_merge.sv
verilog/wr_tlp_gen.sv
verification/clk_gen.sv
verification/tb_wr_tlp_gen.sv

//--- verification/clk_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module clk_gen
  #(
    parameter real PERIOD_NS = 4.0,
    parameter int RESET_CYCLES = 16
    )
   (
    output logic clk,
    output logic reset_n
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset is held low for a fixed number of rising edges, then released on an edge
    initial
    begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

//--- verification/tb_wr_tlp_gen.sv
// Directed testbench for the write TLP generator
// Reference model for write and fence TLPs, stream monitors, checks and timeout
`timescale 1ns/1ps
`include "wr_tlp_defines.svh"

module tb_wr_tlp_gen;

    // The tests take roughly 500 cycles after reset, so the limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic clk;
    logic reset_n;
    logic req_valid;
    logic req_ready;
    afu_wr_pkg::t_afu_wr_req req;
    logic tlp_valid;
    logic tlp_ready;
    pcie_tlp_pkg::t_tlp_hdr tlp_hdr;
    logic [`WR_LINE_BITS-1:0] tlp_payload;
    logic fence_cpl_valid;
    logic fence_cpl_ready;
    afu_wr_pkg::t_fence_tag fence_cpl_tag;
    logic rsp_valid;
    logic rsp_ready;
    afu_wr_pkg::t_afu_wr_rsp rsp;

    integer seed = 32'h04294a1a;
    int cycles = 0;
    int errors = 0;
    logic bp_on = 1'b0;
    string test_name = "reset";

    // Everything that left the DUT in arrival order
    pcie_tlp_pkg::t_tlp_hdr got_hdrs [$];
    logic [`WR_LINE_BITS-1:0] got_payloads [$];
    afu_wr_pkg::t_afu_wr_rsp got_rsps [$];

    // Fence tags the model believes are outstanding, and who owns each
    logic [`WR_MAX_FENCES-1:0] fence_busy;
    afu_wr_pkg::t_afu_tag fence_owner [`WR_MAX_FENCES];

    clk_gen clocks (.clk, .reset_n);

    wr_tlp_gen UUT
       (
        .clk, .reset_n, .req_valid, .req_ready, .req,
        .tlp_valid, .tlp_ready, .tlp_hdr, .tlp_payload,
        .fence_cpl_valid, .fence_cpl_ready, .fence_cpl_tag,
        .rsp_valid, .rsp_ready, .rsp
        );

    // ==============================
    // Monitors, ready drivers, timeout
    // ==============================

    // Transfers are taken on the rising edge, where valid and ready are settled
    always @(posedge clk)
    begin
        if (reset_n && tlp_valid && tlp_ready)
        begin
            got_hdrs.push_back(tlp_hdr);
            got_payloads.push_back(tlp_payload);
        end
        if (reset_n && rsp_valid && rsp_ready)
            got_rsps.push_back(rsp);
    end

    // Consumers are always ready unless back-pressure is switched on
    initial
    begin
        tlp_ready = 1'b1;
        rsp_ready = 1'b1;
        forever
        begin
            @(negedge clk);
            if (bp_on)
            begin
                tlp_ready = (($random(seed) & 3) != 0);
                rsp_ready = (($random(seed) & 1) != 0);
            end
            else
            begin
                tlp_ready = 1'b1;
                rsp_ready = 1'b1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: test %s made no progress within %0d cycles", test_name, cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout");
        end
    end

    // ==============================
    // Reporting and stimulus helpers
    // ==============================
    task automatic abort_run();
        errors++;
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(string what, logic [127:0] expected, logic [127:0] actual);
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED [%s] %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic require(logic cond, string msg);
        assert (cond)
        else
        begin
            $display("ERROR [%s] %s", test_name, msg);
            abort_run();
        end
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [`WR_LINE_BITS-1:0] random_payload();
        return {rand32(), rand32(), rand32(), rand32()};
    endfunction

    // Full-line writes keep their address, so these start on a line boundary
    function automatic logic [63:0] aligned_addr();
        return {rand32(), rand32() & 32'hffff_fff0};
    endfunction

    function automatic afu_wr_pkg::t_afu_wr_req make_req(logic [63:0] addr,
            logic [`WR_LINE_BITS-1:0] payload, afu_wr_pkg::t_afu_tag tag,
            logic is_fence, logic byte_range, int s, int n);
        afu_wr_pkg::t_afu_wr_req r;
        r = '0;
        r.addr = addr;
        r.payload = payload;
        r.tag = tag;
        r.is_fence = is_fence;
        r.enable_byte_range = byte_range;
        r.byte_start_idx = afu_wr_pkg::t_line_byte_idx'(s);
        r.byte_len = afu_wr_pkg::t_byte_len'(n);
        return r;
    endfunction

    // Header of a memory write built from the full-line and byte-range encoding
    function automatic pcie_tlp_pkg::t_tlp_hdr expected_write_hdr(afu_wr_pkg::t_afu_wr_req r);
        pcie_tlp_pkg::t_tlp_hdr h;
        int s;
        int n;
        int last;
        logic [3:0] mask;
        h = '0;
        h.fmttype = pcie_tlp_pkg::MEM_WRITE64;
        h.addr = r.addr;
        if (!r.enable_byte_range)
        begin
            // A whole 16-byte line is four DWORDs
            h.length = 10'd4;
            h.first_be = 4'hf;
            h.last_be = 4'hf;
        end
        else
        begin
            s = int'(r.byte_start_idx);
            n = int'(r.byte_len);
            last = s + n - 1;
            h.length = 10'((s % 4 + n + 3) / 4);
            mask = (n < 4) ? 4'((1 << n) - 1) : 4'hf;
            h.first_be = 4'(mask << (s % 4));
            // One touched DWORD means last_be stays zero
            h.last_be = (s / 4 == last / 4) ? 4'h0 : 4'((1 << (last % 4 + 1)) - 1);
            h.addr[3:2] = 2'(s / 4);
        end
        return h;
    endfunction

    function automatic logic [`WR_LINE_BITS-1:0] shifted_payload(afu_wr_pkg::t_afu_wr_req r);
        if (!r.enable_byte_range)
            return r.payload;
        return r.payload >> (32 * (int'(r.byte_start_idx) / 4));
    endfunction

    task automatic idle(int n);
        repeat (n)
            @(negedge clk);
    endtask

    // Starts and ends on a falling edge and holds the request until it is taken
    task automatic send_req(afu_wr_pkg::t_afu_wr_req r);
        req = r;
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready)
            @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic expect_rsp(afu_wr_pkg::t_afu_tag tag, logic is_fence);
        afu_wr_pkg::t_afu_wr_rsp r;
        while (got_rsps.size() == 0)
            @(negedge clk);
        r = got_rsps.pop_front();
        check_value("response tag", 128'(tag), 128'(r.tag));
        check_value("response is_fence", 128'(is_fence), 128'(r.is_fence));
    endtask

    task automatic expect_write_tlp(afu_wr_pkg::t_afu_wr_req r);
        pcie_tlp_pkg::t_tlp_hdr h;
        logic [`WR_LINE_BITS-1:0] p;
        while (got_hdrs.size() == 0)
            @(negedge clk);
        h = got_hdrs.pop_front();
        p = got_payloads.pop_front();
        check_value("write header", 128'(expected_write_hdr(r)), 128'(h));
        check_value("write payload", shifted_payload(r), p);
    endtask

    // A fence read targets the last write and needs a tag nobody else holds
    task automatic expect_fence_tlp(logic [63:0] addr, afu_wr_pkg::t_afu_tag afu_tag,
                                    output afu_wr_pkg::t_fence_tag tag);
        pcie_tlp_pkg::t_tlp_hdr h;
        while (got_hdrs.size() == 0)
            @(negedge clk);
        h = got_hdrs.pop_front();
        void'(got_payloads.pop_front());
        check_value("read fmttype", 128'(pcie_tlp_pkg::MEM_READ64), 128'(h.fmttype));
        check_value("read length", 128'(1), 128'(h.length));
        check_value("read address", 128'(addr), 128'(h.addr));
        require(h.tag < `WR_MAX_FENCES, $sformatf("fence tag %0d is out of range", h.tag));
        tag = afu_wr_pkg::t_fence_tag'(h.tag);
        require(!fence_busy[tag], $sformatf("fence tag %0d handed out twice", tag));
        fence_busy[tag] = 1'b1;
        fence_owner[tag] = afu_tag;
    endtask

    task automatic complete_fence(afu_wr_pkg::t_fence_tag tag);
        fence_cpl_tag = tag;
        fence_cpl_valid = 1'b1;
        @(posedge clk);
        while (!fence_cpl_ready)
            @(posedge clk);
        @(negedge clk);
        fence_cpl_valid = 1'b0;
        expect_rsp(fence_owner[tag], 1'b1);
        fence_busy[tag] = 1'b0;
    endtask

    // ==============================
    // Directed tests
    // ==============================

    // Must run before any write, while no address is known
    task automatic fence_without_write();
        test_name = "fence_without_write";
        send_req(make_req('0, '0, 8'h5a, 1'b1, 1'b0, 0, 16));
        expect_rsp(8'h5a, 1'b1);
        idle(8);
        check_value("TLPs sent", 128'(0), 128'(got_hdrs.size()));
    endtask

    task automatic full_line_writes();
        afu_wr_pkg::t_afu_wr_req reqs [4];
        test_name = "full_line_writes";
        foreach (reqs[i])
            reqs[i] = make_req(aligned_addr(), random_payload(), 8'(8'h10 + i),
                               1'b0, 1'b0, 0, 16);
        foreach (reqs[i])
            send_req(reqs[i]);
        foreach (reqs[i])
        begin
            expect_write_tlp(reqs[i]);
            expect_rsp(reqs[i].tag, 1'b0);
        end
    endtask

    task automatic byte_range_writes();
        afu_wr_pkg::t_afu_wr_req r;
        int s;
        int n;
        test_name = "byte_range_writes";
        for (int i = 0; i < 16; i++)
        begin
            s = int'(rand32() % 32'd16);
            n = 1 + int'(rand32() % 32'(16 - s));
            r = make_req({rand32(), rand32()}, random_payload(), 8'(8'h20 + i),
                         1'b0, 1'b1, s, n);
            send_req(r);
            expect_write_tlp(r);
            expect_rsp(r.tag, 1'b0);
        end
    endtask

    task automatic fences_after_writes();
        afu_wr_pkg::t_afu_wr_req w;
        afu_wr_pkg::t_fence_tag tags [4];
        test_name = "fences_after_writes";
        // Each round is one write followed by two fences on its address
        for (int round = 0; round < 2; round++)
        begin
            w = make_req(aligned_addr(), random_payload(), 8'(8'h40 + round),
                         1'b0, 1'b0, 0, 16);
            send_req(w);
            send_req(make_req('0, '0, 8'(8'h50 + 2 * round), 1'b1, 1'b0, 0, 16));
            send_req(make_req('0, '0, 8'(8'h51 + 2 * round), 1'b1, 1'b0, 0, 16));
            expect_write_tlp(w);
            expect_rsp(w.tag, 1'b0);
            expect_fence_tlp(w.addr, 8'(8'h50 + 2 * round), tags[2 * round]);
            expect_fence_tlp(w.addr, 8'(8'h51 + 2 * round), tags[2 * round + 1]);
        end
        // Completions return in an order unrelated to issue order
        complete_fence(tags[2]);
        complete_fence(tags[0]);
        complete_fence(tags[3]);
        complete_fence(tags[1]);
    endtask

    task automatic pool_exhaustion();
        afu_wr_pkg::t_afu_wr_req w;
        afu_wr_pkg::t_fence_tag tags [5];
        test_name = "pool_exhaustion";
        w = make_req(aligned_addr(), random_payload(), 8'h60, 1'b0, 1'b0, 0, 16);
        send_req(w);
        expect_write_tlp(w);
        expect_rsp(w.tag, 1'b0);
        for (int i = 0; i < 5; i++)
            send_req(make_req('0, '0, 8'(8'h70 + i), 1'b1, 1'b0, 0, 16));
        for (int i = 0; i < 4; i++)
            expect_fence_tlp(w.addr, 8'(8'h70 + i), tags[i]);
        // The fifth fence sits at the queue head until a tag comes back
        idle(20);
        check_value("reads before a completion", 128'(0), 128'(got_hdrs.size()));
        complete_fence(tags[1]);
        expect_fence_tlp(w.addr, 8'h74, tags[4]);
        complete_fence(tags[4]);
        complete_fence(tags[0]);
        complete_fence(tags[3]);
        complete_fence(tags[2]);
    endtask

    task automatic backpressure();
        afu_wr_pkg::t_afu_wr_req reqs [12];
        int s;
        int n;
        test_name = "backpressure";
        // Stimulus is drawn before the ready drivers start using the seed
        foreach (reqs[i])
        begin
            s = int'(rand32() % 32'd16);
            n = 1 + int'(rand32() % 32'(16 - s));
            if (i % 2 == 0)
                reqs[i] = make_req(aligned_addr(), random_payload(), 8'(8'h90 + i),
                                   1'b0, 1'b0, 0, 16);
            else
                reqs[i] = make_req({rand32(), rand32()}, random_payload(), 8'(8'h90 + i),
                                   1'b0, 1'b1, s, n);
        end
        @(posedge clk);
        bp_on = 1'b1;
        @(negedge clk);
        foreach (reqs[i])
            send_req(reqs[i]);
        foreach (reqs[i])
            expect_write_tlp(reqs[i]);
        foreach (reqs[i])
            expect_rsp(reqs[i].tag, 1'b0);
        @(posedge clk);
        bp_on = 1'b0;
        @(negedge clk);
    endtask

    initial
    begin
        req_valid = 1'b0;
        req = '0;
        fence_cpl_valid = 1'b0;
        fence_cpl_tag = '0;
        fence_busy = '0;
        wait (reset_n === 1'b1);
        @(negedge clk);

        test_name = "reset_state";
        check_value("tlp_valid", 128'(0), 128'(tlp_valid));
        check_value("rsp_valid", 128'(0), 128'(rsp_valid));
        check_value("req_ready", 128'(1), 128'(req_ready));
        check_value("fence_cpl_ready", 128'(1), 128'(fence_cpl_ready));

        fence_without_write();
        full_line_writes();
        byte_range_writes();
        fences_after_writes();
        pool_exhaustion();
        backpressure();

        // Nothing may arrive that the model did not ask for
        idle(8);
        test_name = "end_of_run";
        check_value("leftover TLPs", 128'(0), 128'(got_hdrs.size()));
        check_value("leftover responses", 128'(0), 128'(got_rsps.size()));

        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- verilog/afu_wr_pkg.sv
// AFU write request and response types, fence tag type
`include "wr_tlp_defines.svh"

package afu_wr_pkg;

    typedef logic [`WR_BYTE_IDX_WIDTH-1:0] t_line_byte_idx;
    // Length of a byte range, 1 up to a full line
    typedef logic [`WR_BYTE_IDX_WIDTH:0] t_byte_len;
    typedef logic [`WR_AFU_TAG_WIDTH-1:0] t_afu_tag;
    typedef logic [`WR_FENCE_TAG_WIDTH-1:0] t_fence_tag;

    typedef struct packed {
        logic [63:0] addr;
        logic [`WR_LINE_BITS-1:0] payload;
        t_afu_tag tag;
        logic is_fence;
        // Byte fields are only meaningful when this is set
        logic enable_byte_range;
        t_line_byte_idx byte_start_idx;
        t_byte_len byte_len;
    } t_afu_wr_req;

    typedef struct packed {
        t_afu_tag tag;
        logic is_fence;
    } t_afu_wr_rsp;

endpackage

//--- verilog/fence_tag_if.sv
// Fence tag allocation and release bundle
`timescale 1ns/1ps

interface fence_tag_if;

    // On the allocation side alloc is a single-cycle strobe
    logic alloc;
    logic alloc_ready;
    afu_wr_pkg::t_fence_tag alloc_tag;
    afu_wr_pkg::t_afu_tag alloc_afu_tag;

    // On the release side the stored AFU tag is looked up combinationally
    logic free;
    afu_wr_pkg::t_fence_tag free_tag;
    afu_wr_pkg::t_afu_tag free_afu_tag;

    modport pool (input alloc, alloc_afu_tag, free, free_tag,
                  output alloc_ready, alloc_tag, free_afu_tag);
    modport requester (output alloc, alloc_afu_tag, input alloc_ready, alloc_tag);
    modport completer (output free, free_tag, input free_afu_tag);

endinterface

//--- verilog/fence_tag_pool.sv
// Fence tag allocator with busy bits, in-flight count and AFU tag store
`timescale 1ns/1ps
`include "wr_tlp_defines.svh"

module fence_tag_pool
   (
    input  logic clk,
    input  logic reset_n,

    fence_tag_if.pool tags
    );

    localparam int N = `WR_MAX_FENCES;
    localparam int CNT_W = $clog2(N) + 1;
    localparam logic [CNT_W-1:0] ALL_BUSY = CNT_W'(N);

    logic [N-1:0] busy;
    logic [CNT_W-1:0] in_flight;
    // AFU tag saved per fence tag until the completion returns
    afu_wr_pkg::t_afu_tag afu_tags [N];

    assign tags.alloc_ready = (in_flight != ALL_BUSY);
    assign tags.free_afu_tag = afu_tags[tags.free_tag];

    // Lowest free tag wins, scanning down so the last hit is the smallest
    always_comb
    begin
        tags.alloc_tag = '0;
        for (int i = N - 1; i >= 0; i--)
            if (!busy[i])
                tags.alloc_tag = afu_wr_pkg::t_fence_tag'(i);
    end

    always_ff @(posedge clk)
    begin
        if (tags.alloc)
            afu_tags[tags.alloc_tag] <= tags.alloc_afu_tag;
    end

    // Alloc and free never hit the same tag, one is free and one is busy
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy <= '0;
            in_flight <= '0;
        end
        else
        begin
            if (tags.alloc)
                busy[tags.alloc_tag] <= 1'b1;
            if (tags.free)
                busy[tags.free_tag] <= 1'b0;
            in_flight <= in_flight + CNT_W'(tags.alloc) - CNT_W'(tags.free);
        end
    end

    // A completion must match a fence that is actually outstanding
    assert property (@(posedge clk) disable iff (!reset_n) tags.free |-> busy[tags.free_tag]);

endmodule

//--- verilog/fifo2.sv
// Two-entry FIFO with a configurable payload type
`timescale 1ns/1ps

module fifo2
  #(
    parameter type t_item = logic
    )
   (
    input  logic clk,
    input  logic reset_n,

    input  logic enq_en,
    input  t_item enq_data,
    output logic not_full,

    input  logic deq_en,
    output t_item first,
    output logic not_empty
    );

    t_item mem [2];
    logic wr_ptr;
    logic rd_ptr;
    // Occupancy from 0 to 2
    logic [1:0] count;

    assign not_full = (count != 2'd2);
    assign not_empty = (count != 2'd0);
    assign first = mem[rd_ptr];

    // Entries are written at the write pointer
    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= !wr_ptr;
            if (deq_en)
                rd_ptr <= !rd_ptr;
            count <= count + 2'(enq_en) - 2'(deq_en);
        end
    end

    // Callers must honor the flags
    assert property (@(posedge clk) disable iff (!reset_n) enq_en |-> not_full);
    assert property (@(posedge clk) disable iff (!reset_n) deq_en |-> not_empty);

endmodule

//--- verilog/pcie_tlp_pkg.sv
// PCIe TLP header struct and the format/type codes in use

package pcie_tlp_pkg;

    typedef logic [7:0] t_fmttype;

    // 4 DW header with 64-bit address
    localparam t_fmttype MEM_WRITE64 = 8'h60;
    localparam t_fmttype MEM_READ64 = 8'h20;

    // Byte enable for the first or last DWORD of a request
    typedef logic [3:0] t_be;

    // ==============================
    // Memory request header
    // ==============================
    typedef struct packed {
        t_fmttype fmttype;
        // Payload length in DWORDs
        logic [9:0] length;
        logic [7:0] tag;
        t_be first_be;
        t_be last_be;
        logic [63:0] addr;
    } t_tlp_hdr;

endpackage

//--- verilog/tlp_builder.sv
// Byte range math, TLP header assembly, payload shift
// and the registered TLP output
`timescale 1ns/1ps
`include "wr_tlp_defines.svh"

module tlp_builder
   (
    input  logic clk,
    input  logic reset_n,

    input  logic dispatch,
    input  logic fence_sent,
    input  afu_wr_pkg::t_afu_wr_req req,
    input  logic [63:0] last_addr,
    input  afu_wr_pkg::t_fence_tag fence_tag,

    output logic slot_free,
    output logic tlp_valid,
    input  logic tlp_ready,
    output pcie_tlp_pkg::t_tlp_hdr tlp_hdr,
    output logic [`WR_LINE_BITS-1:0] tlp_payload
    );

    localparam int DW_HI = `WR_BYTE_IDX_WIDTH - 1;

    afu_wr_pkg::t_line_byte_idx start_idx;
    logic [4:0] end_sum;
    logic [4:0] dw_sum;
    logic [3:0] first_mask;
    pcie_tlp_pkg::t_be first_be;
    pcie_tlp_pkg::t_be last_be;
    logic [63:0] wr_addr;
    logic [`WR_LINE_BITS-1:0] shifted;
    pcie_tlp_pkg::t_tlp_hdr hdr;
    logic load;

    // ==============================
    // Byte range math
    // ==============================

    // Full-line writes behave like a range starting at byte 0
    assign start_idx = req.enable_byte_range ? req.byte_start_idx : '0;
    assign end_sum = {1'b0, start_idx} + req.byte_len - 5'd1;
    assign dw_sum = {3'b0, start_idx[1:0]} + req.byte_len + 5'd3;

    always_comb
    begin
        // Short ranges may start and end inside the first DWORD
        first_mask = 4'hf;
        if (req.byte_len < 4)
        begin
            case (req.byte_len[1:0])
                2'b01: first_mask = 4'h1;
                2'b10: first_mask = 4'h3;
                2'b11: first_mask = 4'h7;
                default: first_mask = 4'h0;
            endcase
        end
        first_be = first_mask << start_idx[1:0];

        // PCIe wants last_be zero when only one DWORD is touched
        last_be = 4'h0;
        if (start_idx[DW_HI:2] != end_sum[DW_HI:2])
        begin
            case (end_sum[1:0])
                2'b00: last_be = 4'h1;
                2'b01: last_be = 4'h3;
                2'b10: last_be = 4'h7;
                default: last_be = 4'hf;
            endcase
        end

        wr_addr = req.addr;
        wr_addr[DW_HI:2] = start_idx[DW_HI:2];
    end

    // Move the first used DWORD down to lane 0, a no-op for full lines
    assign shifted = req.payload >> {start_idx[DW_HI:2], 5'b0};

    // ==============================
    // Header assembly
    // ==============================
    always_comb
    begin
        hdr = '0;
        if (req.is_fence)
        begin
            // A fence is a one-DWORD read that trails the last write
            hdr.fmttype = pcie_tlp_pkg::MEM_READ64;
            hdr.length = 10'd1;
            hdr.tag = 8'(fence_tag);
            hdr.first_be = 4'hf;
            hdr.addr = last_addr;
        end
        else
        begin
            hdr.fmttype = pcie_tlp_pkg::MEM_WRITE64;
            hdr.length = req.enable_byte_range ? 10'(dw_sum[4:2]) : 10'(`WR_LINE_BYTES / 4);
            hdr.first_be = req.enable_byte_range ? first_be : 4'hf;
            hdr.last_be = req.enable_byte_range ? last_be : 4'hf;
            hdr.addr = wr_addr;
        end
    end

    assign slot_free = !tlp_valid || tlp_ready;
    // Fences with no address are answered directly and send nothing
    assign load = dispatch && (!req.is_fence || fence_sent);

    always_ff @(posedge clk)
    begin
        if (slot_free && load)
        begin
            tlp_hdr <= hdr;
            tlp_payload <= req.is_fence ? '0 : shifted;
        end

        if (!reset_n)
            tlp_valid <= 1'b0;
        else if (slot_free)
            tlp_valid <= load;
    end

    // A stalled TLP must not change under the consumer
    assert property (@(posedge clk) disable iff (!reset_n)
                     tlp_valid && !tlp_ready |=> tlp_valid && $stable(tlp_hdr));

endmodule

//--- verilog/wr_req_sequencer.sv
// Request dispatch control and last write address tracking
`timescale 1ns/1ps

module wr_req_sequencer
   (
    input  logic clk,
    input  logic reset_n,

    input  afu_wr_pkg::t_afu_wr_req head,
    input  logic head_valid,
    output logic deq,

    input  logic tlp_slot_free,
    input  logic rsp_room,

    fence_tag_if.requester tags,

    output logic dispatch,
    output logic fence_sent,
    output logic [63:0] last_addr
    );

    typedef enum logic {
        ST_NO_ADDR,
        ST_ADDR_KNOWN
    } t_state;

    t_state state;
    t_state state_next;
    logic needs_tag;

    // A fence only becomes a read TLP once some write has gone out
    assign needs_tag = head.is_fence && (state == ST_ADDR_KNOWN);

    // Every request takes a response slot, a real fence also takes a tag
    assign dispatch = head_valid && tlp_slot_free && rsp_room &&
                      (!needs_tag || tags.alloc_ready);
    assign deq = dispatch;

    assign fence_sent = dispatch && needs_tag;
    assign tags.alloc = fence_sent;
    assign tags.alloc_afu_tag = head.tag;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_NO_ADDR:
                if (dispatch && !head.is_fence)
                    state_next = ST_ADDR_KNOWN;
            default:
                state_next = ST_ADDR_KNOWN;
        endcase
    end

    always_ff @(posedge clk)
    begin
        // Fences target the address of the most recent write as sent
        if (dispatch && !head.is_fence)
            last_addr <= head.addr;

        if (!reset_n)
            state <= ST_NO_ADDR;
        else
            state <= state_next;
    end

endmodule

//--- verilog/wr_rsp_merge.sv
// Fence completion register, normal response queue and
// prioritized AFU response queue
`timescale 1ns/1ps

module wr_rsp_merge
   (
    input  logic clk,
    input  logic reset_n,

    input  logic dispatch,
    input  logic fence_sent,
    input  afu_wr_pkg::t_afu_tag req_tag,
    input  logic req_is_fence,
    output logic room,

    input  logic fence_cpl_valid,
    output logic fence_cpl_ready,
    input  afu_wr_pkg::t_fence_tag fence_cpl_tag,

    fence_tag_if.completer tags,

    output logic rsp_valid,
    input  logic rsp_ready,
    output afu_wr_pkg::t_afu_wr_rsp rsp
    );

    afu_wr_pkg::t_afu_wr_rsp norm_in;
    afu_wr_pkg::t_afu_wr_rsp norm_head;
    afu_wr_pkg::t_afu_wr_rsp out_in;
    logic norm_valid;
    logic norm_deq;
    logic out_room;
    logic cpl_valid_q;
    afu_wr_pkg::t_fence_tag cpl_tag_q;

    // Writes and address-less fences are answered at dispatch
    assign norm_in = '{tag: req_tag, is_fence: req_is_fence};

    fifo2 #(.t_item(afu_wr_pkg::t_afu_wr_rsp)) norm_fifo
       (
        .clk,
        .reset_n,
        .enq_en(dispatch && !fence_sent),
        .enq_data(norm_in),
        .not_full(room),
        .deq_en(norm_deq),
        .first(norm_head),
        .not_empty(norm_valid)
        );

    // ==============================
    // Fence completion register
    // ==============================
    assign fence_cpl_ready = !cpl_valid_q;

    always_ff @(posedge clk)
    begin
        if (!cpl_valid_q)
            cpl_tag_q <= fence_cpl_tag;

        if (!reset_n)
            cpl_valid_q <= 1'b0;
        else if (!cpl_valid_q)
            cpl_valid_q <= fence_cpl_valid;
        else if (out_room)
            cpl_valid_q <= 1'b0;
    end

    // The tag goes back to the pool in the cycle its response moves on
    assign tags.free = cpl_valid_q && out_room;
    assign tags.free_tag = cpl_tag_q;

    // Completions win over queued normal responses
    assign norm_deq = norm_valid && out_room && !cpl_valid_q;
    assign out_in = cpl_valid_q ?
                    afu_wr_pkg::t_afu_wr_rsp'{tag: tags.free_afu_tag, is_fence: 1'b1} :
                    norm_head;

    fifo2 #(.t_item(afu_wr_pkg::t_afu_wr_rsp)) out_fifo
       (
        .clk,
        .reset_n,
        .enq_en(tags.free || norm_deq),
        .enq_data(out_in),
        .not_full(out_room),
        .deq_en(rsp_valid && rsp_ready),
        .first(rsp),
        .not_empty(rsp_valid)
        );

endmodule

//--- verilog/wr_tlp_defines.svh
// Sizing macros for the write TLP generator
// Line size, tag widths and fence pool depth
`ifndef WR_TLP_DEFINES_SVH
`define WR_TLP_DEFINES_SVH

// Bytes in one payload line, which is one TLP beat
`define WR_LINE_BYTES 16
`define WR_LINE_BITS (`WR_LINE_BYTES * 8)
`define WR_BYTE_IDX_WIDTH $clog2(`WR_LINE_BYTES)

// Tag the AFU attaches to each request and gets back in its response
`define WR_AFU_TAG_WIDTH 8

// Fences that may wait for a completion at the same time
`define WR_MAX_FENCES 4
`define WR_FENCE_TAG_WIDTH $clog2(`WR_MAX_FENCES)

`endif

//--- verilog/wr_tlp_gen.sv
// Write request TLP generator top level
`timescale 1ns/1ps
`include "wr_tlp_defines.svh"

module wr_tlp_gen
   (
    input  logic clk,
    input  logic reset_n,

    input  logic req_valid,
    output logic req_ready,
    input  afu_wr_pkg::t_afu_wr_req req,

    output logic tlp_valid,
    input  logic tlp_ready,
    output pcie_tlp_pkg::t_tlp_hdr tlp_hdr,
    output logic [`WR_LINE_BITS-1:0] tlp_payload,

    input  logic fence_cpl_valid,
    output logic fence_cpl_ready,
    input  afu_wr_pkg::t_fence_tag fence_cpl_tag,

    output logic rsp_valid,
    input  logic rsp_ready,
    output afu_wr_pkg::t_afu_wr_rsp rsp
    );

    afu_wr_pkg::t_afu_wr_req head;
    logic head_valid;
    logic head_deq;
    logic slot_free;
    logic rsp_room;
    logic dispatch;
    logic fence_sent;
    logic [63:0] last_addr;

    fence_tag_if tag_bus ();

    // Incoming requests are buffered before dispatch
    fifo2 #(.t_item(afu_wr_pkg::t_afu_wr_req)) req_fifo
       (
        .clk, .reset_n,
        .enq_en(req_valid && req_ready), .enq_data(req), .not_full(req_ready),
        .deq_en(head_deq), .first(head), .not_empty(head_valid)
        );

    fence_tag_pool pool (.clk, .reset_n, .tags(tag_bus.pool));

    wr_req_sequencer seq
       (
        .clk, .reset_n, .head, .head_valid, .deq(head_deq),
        .tlp_slot_free(slot_free), .rsp_room, .tags(tag_bus.requester),
        .dispatch, .fence_sent, .last_addr
        );

    tlp_builder builder
       (
        .clk, .reset_n, .dispatch, .fence_sent, .req(head), .last_addr,
        .fence_tag(tag_bus.alloc_tag), .slot_free,
        .tlp_valid, .tlp_ready, .tlp_hdr, .tlp_payload
        );

    wr_rsp_merge merge
       (
        .clk, .reset_n, .dispatch, .fence_sent,
        .req_tag(head.tag), .req_is_fence(head.is_fence), .room(rsp_room),
        .fence_cpl_valid, .fence_cpl_ready, .fence_cpl_tag,
        .tags(tag_bus.completer), .rsp_valid, .rsp_ready, .rsp
        );

endmodule
